/* files.f */
armPkg.sv
shifter.sv
alu.sv
flagUnit.sv
executeStage.sv
executeStage_assert.sv
tbExecute.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then search the log for the failure line
rm -f sim.log
verilator --binary --timing --assert --top-module tbExecute -f files.f -o simExecute \
  && ./obj_dir/simExecute +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0

/* tbExecute.sv */
`timescale 1ns/1ps

module tbExecute;

  import armPkg::*;

  logic        clk = 1'b0;
  logic        rstN;
  logic        validE;
  execCtrlT    ctrlE;
  logic [31:0] rnE;
  logic [31:0] rmE;
  logic [31:0] rsE;
  logic [31:0] resultM;
  logic        validM;
  logic        regWriteM;
  flagsT       flags;
  logic [31:0] lfsr = 32'h1c92_1739;
  logic [7:0]  amounts [6] = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd255};

  executeStage #(.FlagsReset(flagsT'(4'b0010))) DUT (.*);  // C set out of reset

  always #4 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic issue(input logic [3:0] op, input logic [3:0] cond, input logic s,
                       input logic [1:0] form, input logic [1:0] sh, input logic [4:0] imm,
                       input logic [31:0] rn, input logic [31:0] rm, input logic [31:0] rs);
    @(posedge clk);
    validE          <= 1'b1;
    ctrlE.aluOp     <= aluOpT'(op);
    ctrlE.cond      <= condT'(cond);
    ctrlE.setFlags  <= s || (op[3:2] == 2'b10);  // TST TEQ CMP CMN always set flags
    ctrlE.writesReg <= (op[3:2] != 2'b10);
    ctrlE.isRtype   <= (form == 2'd1);
    ctrlE.isRSRtype <= form[1];
    ctrlE.shiftOp   <= shiftOpT'(sh);
    ctrlE.shiftImm  <= imm;
    rnE             <= rn;
    rmE             <= rm;
    rsE             <= rs;
  endtask

  task automatic idle();
    @(posedge clk);
    validE <= 1'b0;
  endtask

  task automatic randomIssue();
    logic [3:0]  op;
    logic [3:0]  cond;
    logic        s;
    logic [1:0]  form;
    logic [1:0]  sh;
    logic [4:0]  imm;
    logic [31:0] rn;
    logic [31:0] rm;
    logic [31:0] rs;
    op   = 4'(randBits(4));
    cond = 4'(randBits(4));
    if (randBits(1) == 32'd1) cond = CondAl;
    s    = 1'(randBits(1));
    form = 2'(randBits(2));
    sh   = 2'(randBits(2));
    imm  = 5'(randBits(5));
    rn   = randBits(32);
    rm   = randBits(32);
    rs   = randBits(32);
    if (rs[31]) rs[7:0] = {2'b00, rs[13:8]};  // Keep small amounts common
    issue(op, cond, s, form, sh, imm, rn, rm, rs);
  endtask

  task automatic waitQuiet(input string what);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 50) begin
        $display("STATUS: FAIL");
        $fatal(1, "timeout after 50 cycles waiting for %s", what);
      end
    end while (!(rstN === 1'b1 && validM === 1'b0));
  endtask

  always @(posedge clk) begin
    if (DUT.uCheck.failCount != 0) begin
      $display("STATUS: FAIL");
      $fatal(1, "execute stage checker reported a mismatch");
    end
  end

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    rstN            = 1'b0;
    validE          = 1'b1;  // MVNS held busy through reset
    ctrlE           = '0;
    ctrlE.aluOp     = OpMvn;
    ctrlE.cond      = CondAl;
    ctrlE.setFlags  = 1'b1;
    ctrlE.writesReg = 1'b1;
    rnE             = '0;
    rmE             = '0;
    rsE             = '0;
    repeat (16) @(posedge clk);
    rstN   <= 1'b1;
    validE <= 1'b0;
    waitQuiet("reset release");
    // Boundary amounts in both shift forms with MOVS so C follows the shifter
    foreach (amounts[i]) begin
      for (int f = 1; f <= 2; f++) begin
        for (int sh = 0; sh < 4; sh++) begin
          a = randBits(32);
          issue(4'hd, 4'he, 1'b1, 2'(f), 2'(sh), amounts[i][4:0], 32'd0, a, {24'd0, amounts[i]});
        end
      end
    end
    // Every opcode followed by chained ADC and SBC
    for (int k = 0; k < 64; k++) begin
      a = randBits(32);
      b = randBits(32);
      issue(4'(k), 4'he, 1'b1, 2'd0, 2'd0, 5'd0, a, b, 32'd0);
      issue(4'h5, 4'he, 1'b1, 2'd0, 2'd0, 5'd0, a, ~b, 32'd0);
      issue(4'h6, 4'he, 1'b1, 2'd0, 2'd0, 5'd0, b, a, 32'd0);
    end
    for (int k = 0; k < 400; k++) begin
      randomIssue();
      if (randBits(3) == 32'd0) idle();
    end
    idle();
    waitQuiet("pipeline drain");
    if (DUT.uCheck.failCount == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      $display("STATUS: FAIL");
      $fatal(1, "execute stage checker reported a mismatch");
    end
  end

endmodule

/* executeStage_assert.sv */
`timescale 1ns/1ps

module executeStage_assert #(
  parameter armPkg::flagsT FlagsReset = armPkg::flagsResetC
) (
  input logic             clk,
  input logic             rstN,
  input logic             validE,
  input armPkg::execCtrlT ctrlE,
  input logic [31:0]      rnE,
  input logic [31:0]      rmE,
  input logic [31:0]      rsE,
  input logic [31:0]      resultM,
  input logic             validM,
  input logic             regWriteM,
  input armPkg::flagsT    flags
);

  import armPkg::*;

  int          failCount = 0;
  flagsT       flagsModel;
  flagsT       flagsRef;
  logic [32:0] shRef;     // {carry, value}
  logic [33:0] arRef;     // {c, v, sum}
  logic [31:0] resRef;
  logic        passRef;
  logic        logicOp;
  logic [31:0] expResult;
  logic        expValid;
  logic        expRegWrite;

  // Shifts one bit per step, so amounts of 32 and more need no special case
  function automatic logic [32:0] refShift(execCtrlT c, logic [31:0] v, logic [31:0] s,
                                           logic cin);
    logic [31:0] val;
    logic        carry;
    int          n;
    val   = v;
    carry = cin;
    n     = 0;
    if (c.isRtype) begin
      n = int'(c.shiftImm);
      if (n == 0 && c.shiftOp == ShRor) return {v[0], cin, v[31:1]};  // RRX
      if (n == 0 && c.shiftOp != ShLsl) n = 32;
    end else if (c.isRSRtype) begin
      n = int'(s[7:0]);
    end
    for (int i = 0; i < n; i++) begin
      carry = (c.shiftOp == ShLsl) ? val[31] : val[0];
      case (c.shiftOp)
        ShLsl:   val = {val[30:0], 1'b0};
        ShLsr:   val = {1'b0, val[31:1]};
        ShAsr:   val = {val[31], val[31:1]};
        default: val = {val[0], val[31:1]};
      endcase
    end
    return {carry, val};
  endfunction

  // Wide signed and unsigned sums give C and V without the adder trick
  function automatic logic [33:0] refArith(logic [31:0] a, logic [31:0] b, logic sub,
                                           logic cin);
    longint u;
    longint s;
    if (sub) begin
      u = longint'({32'd0, a}) - longint'({32'd0, b}) - longint'({63'd0, !cin});
      s = longint'($signed(a)) - longint'($signed(b)) - longint'({63'd0, !cin});
    end else begin
      u = longint'({32'd0, a}) + longint'({32'd0, b}) + longint'({63'd0, cin});
      s = longint'($signed(a)) + longint'($signed(b)) + longint'({63'd0, cin});
    end
    return {sub ? !u[63] : u[32], (s > 64'sd2147483647) || (s < -64'sd2147483648), u[31:0]};
  endfunction

  // Odd codes invert the even code below them
  function automatic logic refCond(logic [3:0] cc, flagsT f);
    logic base;
    case (cc[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = ~cc[0];  // AL and NV
    endcase
    return (cc[3:1] == 3'd7) ? base : base ^ cc[0];
  endfunction

  always_comb begin
    shRef   = refShift(ctrlE, rmE, rsE, flagsModel.c);
    passRef = refCond(ctrlE.cond, flagsModel);
    logicOp = ctrlE.aluOp inside {OpAnd, OpEor, OpTst, OpTeq, OpOrr, OpMov, OpBic, OpMvn};
    case (ctrlE.aluOp)
      OpSub, OpCmp: arRef = refArith(rnE, shRef[31:0], 1'b1, 1'b1);
      OpRsb:        arRef = refArith(shRef[31:0], rnE, 1'b1, 1'b1);
      OpAdd, OpCmn: arRef = refArith(rnE, shRef[31:0], 1'b0, 1'b0);
      OpAdc:        arRef = refArith(rnE, shRef[31:0], 1'b0, flagsModel.c);
      OpSbc:        arRef = refArith(rnE, shRef[31:0], 1'b1, flagsModel.c);
      OpRsc:        arRef = refArith(shRef[31:0], rnE, 1'b1, flagsModel.c);
      default:      arRef = '0;
    endcase
    case (ctrlE.aluOp)
      OpAnd, OpTst: resRef = rnE & shRef[31:0];
      OpEor, OpTeq: resRef = rnE ^ shRef[31:0];
      OpOrr:        resRef = rnE | shRef[31:0];
      OpMov:        resRef = shRef[31:0];
      OpBic:        resRef = rnE & ~shRef[31:0];
      OpMvn:        resRef = ~shRef[31:0];
      default:      resRef = arRef[31:0];
    endcase
    flagsRef.n = resRef[31];
    flagsRef.z = (resRef == 32'd0);
    flagsRef.c = logicOp ? shRef[32] : arRef[33];
    flagsRef.v = logicOp ? flagsModel.v : arRef[32];
  end

  always @(posedge clk) begin
    if (!rstN) begin
      flagsModel  <= FlagsReset;
      expValid    <= 1'b0;
      expRegWrite <= 1'b0;
      expResult   <= '0;
    end else begin
      expValid    <= validE;
      expRegWrite <= validE && passRef && ctrlE.writesReg;
      expResult   <= resRef;
      if (validE && passRef && ctrlE.setFlags) flagsModel <= flagsRef;
    end
  end

  // Checked mid cycle where the registered outputs are settled
  assert property (@(negedge clk) disable iff (!rstN) validM == expValid)
    else begin
      failCount++;
      $error("error %0t: validM %b expected %b", $time, validM, expValid);
    end

  assert property (@(negedge clk) disable iff (!rstN) regWriteM == expRegWrite)
    else begin
      failCount++;
      $error("error %0t: regWriteM %b expected %b", $time, regWriteM, expRegWrite);
    end

  assert property (@(negedge clk) disable iff (!rstN) expValid |-> resultM == expResult)
    else begin
      failCount++;
      $error("error %0t: resultM %h expected %h", $time, resultM, expResult);
    end

  assert property (@(negedge clk) disable iff (!rstN) flags == flagsModel)
    else begin
      failCount++;
      $error("error %0t: flags %b expected %b", $time, flags, flagsModel);
    end

endmodule

bind executeStage executeStage_assert #(.FlagsReset(FlagsReset)) uCheck (.*);

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage #(
  parameter armPkg::flagsT FlagsReset = armPkg::flagsResetC
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             validE,
  input  armPkg::execCtrlT ctrlE,
  input  logic [31:0]      rnE,
  input  logic [31:0]      rmE,
  input  logic [31:0]      rsE,
  output logic [31:0]      resultM,
  output logic             validM,
  output logic             regWriteM,
  output armPkg::flagsT    flags
);

  import armPkg::*;

  logic [31:0] shiftedE;
  logic        shifterCarryE;
  logic        condPassE;
  logic        flagWriteE;
  flagsT       newFlagsE;

  shifter uShifter (
    .ctrl         (ctrlE),
    .rm           (rmE),
    .rs           (rsE),
    .carryIn      (flags.c),
    .shifted      (shiftedE),
    .shifterCarry (shifterCarryE)
  );

  alu uAlu (
    .clk          (clk),
    .rstN         (rstN),
    .validE       (validE),
    .ctrl         (ctrlE),
    .rn           (rnE),
    .op2          (shiftedE),
    .shifterCarry (shifterCarryE),
    .flagsIn      (flags),
    .condPass     (condPassE),
    .newFlags     (newFlagsE),
    .flagWrite    (flagWriteE),
    .resultM      (resultM),
    .validM       (validM),
    .regWriteM    (regWriteM)
  );

  flagUnit #(
    .FlagsReset (FlagsReset)
  ) uFlagUnit (
    .clk       (clk),
    .rstN      (rstN),
    .cond      (ctrlE.cond),
    .flagWrite (flagWriteE),
    .newFlags  (newFlagsE),
    .flags     (flags),
    .condPass  (condPassE)
  );

endmodule

/* flagUnit.sv */
`timescale 1ns/1ps

module flagUnit #(
  parameter armPkg::flagsT FlagsReset = armPkg::flagsResetC
) (
  input  logic          clk,
  input  logic          rstN,
  input  armPkg::condT  cond,
  input  logic          flagWrite,
  input  armPkg::flagsT newFlags,
  output armPkg::flagsT flags,
  output logic          condPass
);

  import armPkg::*;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= FlagsReset;
    end else if (flagWrite) begin
      flags <= newFlags;
    end
  end

  // Checked against the registered flags, so a write lands for the next issue
  always_comb begin
    case (cond)
      CondEq: condPass = flags.z;
      CondNe: condPass = !flags.z;
      CondCs: condPass = flags.c;
      CondCc: condPass = !flags.c;
      CondMi: condPass = flags.n;
      CondPl: condPass = !flags.n;
      CondVs: condPass = flags.v;
      CondVc: condPass = !flags.v;
      CondHi: condPass = flags.c && !flags.z;
      CondLs: condPass = !flags.c || flags.z;
      CondGe: condPass = (flags.n == flags.v);
      CondLt: condPass = (flags.n != flags.v);
      CondGt: condPass = !flags.z && (flags.n == flags.v);
      CondLe: condPass = flags.z || (flags.n != flags.v);
      CondAl: condPass = 1'b1;
      CondNv: condPass = 1'b0;  // Never
    endcase
  end

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic             clk,
  input  logic             rstN,
  input  logic             validE,
  input  armPkg::execCtrlT ctrl,
  input  logic [31:0]      rn,
  input  logic [31:0]      op2,
  input  logic             shifterCarry,
  input  armPkg::flagsT    flagsIn,
  input  logic             condPass,
  output armPkg::flagsT    newFlags,
  output logic             flagWrite,
  output logic [31:0]      resultM,
  output logic             validM,
  output logic             regWriteM
);

  import armPkg::*;

  logic [31:0] addA;
  logic [31:0] addB;
  logic        addCin;
  logic        isArith;
  logic [32:0] sum;
  logic        overflow;
  logic [31:0] result;

  // Operand steering so a single adder covers every arithmetic opcode
  always_comb begin
    addA    = rn;
    addB    = op2;
    addCin  = 1'b0;
    isArith = 1'b1;
    case (ctrl.aluOp)
      OpSub, OpCmp: begin
        addB   = ~op2;
        addCin = 1'b1;
      end
      OpRsb: begin
        addA   = op2;
        addB   = ~rn;
        addCin = 1'b1;
      end
      OpAdd, OpCmn: addCin = 1'b0;
      OpAdc: addCin = flagsIn.c;
      OpSbc: begin
        addB   = ~op2;
        addCin = flagsIn.c;  // Borrow is not C
      end
      OpRsc: begin
        addA   = op2;
        addB   = ~rn;
        addCin = flagsIn.c;
      end
      default: isArith = 1'b0;
    endcase
  end

  assign sum      = {1'b0, addA} + {1'b0, addB} + {32'd0, addCin};
  assign overflow = (addA[31] == addB[31]) && (sum[31] != addA[31]);

  always_comb begin
    case (ctrl.aluOp)
      OpAnd, OpTst: result = rn & op2;
      OpEor, OpTeq: result = rn ^ op2;
      OpOrr:        result = rn | op2;
      OpMov:        result = op2;
      OpBic:        result = rn & ~op2;
      OpMvn:        result = ~op2;
      default:      result = sum[31:0];
    endcase
  end

  assign newFlags.n = result[31];
  assign newFlags.z = (result == 32'd0);
  assign newFlags.c = isArith ? sum[32] : shifterCarry;
  assign newFlags.v = isArith ? overflow : flagsIn.v;  // Logical ops keep V

  assign flagWrite = validE & condPass & ctrl.setFlags;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      resultM   <= '0;
      validM    <= 1'b0;
      regWriteM <= 1'b0;
    end else begin
      resultM   <= result;
      validM    <= validE;
      regWriteM <= validE & condPass & ctrl.writesReg;
    end
  end

endmodule

/* shifter.sv */
`timescale 1ns/1ps

module shifter (
  input  armPkg::execCtrlT ctrl,
  input  logic [31:0]      rm,
  input  logic [31:0]      rs,
  input  logic             carryIn,
  output logic [31:0]      shifted,
  output logic             shifterCarry
);

  import armPkg::*;

  logic [7:0]  rsByte;
  logic [5:0]  amt;       // Effective amount, up to 32
  logic        passThru;
  logic        bigAmt;    // Register amount above 32
  logic        rrx;
  logic [32:0] lslWide;   // Carry in bit 32
  logic [32:0] lsrWide;   // Carry in bit 0
  logic [32:0] asrWide;   // Carry in bit 0
  logic [63:0] rorWide;

  assign rsByte = rs[7:0];

  // Work out the amount and the special cases for both operand forms
  always_comb begin
    amt      = '0;
    passThru = 1'b1;
    bigAmt   = 1'b0;
    rrx      = 1'b0;
    if (ctrl.isRtype) begin
      passThru = 1'b0;
      if (ctrl.shiftImm != 5'd0) begin
        amt = {1'b0, ctrl.shiftImm};
      end else begin
        case (ctrl.shiftOp)
          ShLsl: passThru = 1'b1;  // LSL #0 keeps value and carry
          ShLsr: amt = 6'd32;      // LSR #0 means #32
          ShAsr: amt = 6'd32;
          ShRor: rrx = 1'b1;
        endcase
      end
    end else if (ctrl.isRSRtype) begin
      if (rsByte != 8'd0) begin
        passThru = 1'b0;
        if (ctrl.shiftOp == ShRor) begin
          amt = {1'b0, rsByte[4:0]};  // Rotate modulo 32
        end else if (rsByte > 8'd32) begin
          bigAmt = 1'b1;
          amt    = 6'd32;
        end else begin
          amt = rsByte[5:0];
        end
      end
    end
  end

  // Extra bit beside the data catches the last bit shifted out
  assign lslWide = {1'b0, rm} << amt;
  assign lsrWide = {rm, 1'b0} >> amt;
  assign asrWide = $signed({rm, 1'b0}) >>> amt;
  assign rorWide = {rm, rm} >> amt[4:0];

  always_comb begin
    shifted      = rm;
    shifterCarry = carryIn;
    if (rrx) begin
      shifted      = {carryIn, rm[31:1]};
      shifterCarry = rm[0];
    end else if (!passThru) begin
      case (ctrl.shiftOp)
        ShLsl: begin
          if (bigAmt) begin
            shifted      = '0;
            shifterCarry = 1'b0;
          end else begin
            shifted      = lslWide[31:0];
            shifterCarry = lslWide[32];
          end
        end
        ShLsr: begin
          if (bigAmt) begin
            shifted      = '0;
            shifterCarry = 1'b0;
          end else begin
            shifted      = lsrWide[32:1];
            shifterCarry = lsrWide[0];
          end
        end
        ShAsr: begin
          shifted      = asrWide[32:1];  // Amounts past 32 act as 32
          shifterCarry = asrWide[0];
        end
        ShRor: begin
          shifted      = rorWide[31:0];
          shifterCarry = rorWide[31];    // Bit 31 also for multiples of 32
        end
      endcase
    end
  end

endmodule

/* armPkg.sv */
package armPkg;

  typedef enum logic [3:0] {
    OpAnd = 4'h0,
    OpEor = 4'h1,
    OpSub = 4'h2,
    OpRsb = 4'h3,
    OpAdd = 4'h4,
    OpAdc = 4'h5,
    OpSbc = 4'h6,
    OpRsc = 4'h7,
    OpTst = 4'h8,
    OpTeq = 4'h9,
    OpCmp = 4'ha,
    OpCmn = 4'hb,
    OpOrr = 4'hc,
    OpMov = 4'hd,
    OpBic = 4'he,
    OpMvn = 4'hf
  } aluOpT;

  typedef enum logic [1:0] {
    ShLsl = 2'b00,
    ShLsr = 2'b01,
    ShAsr = 2'b10,
    ShRor = 2'b11  // RRX when immediate amount is zero
  } shiftOpT;

  typedef enum logic [3:0] {
    CondEq = 4'h0,
    CondNe = 4'h1,
    CondCs = 4'h2,
    CondCc = 4'h3,
    CondMi = 4'h4,
    CondPl = 4'h5,
    CondVs = 4'h6,
    CondVc = 4'h7,
    CondHi = 4'h8,
    CondLs = 4'h9,
    CondGe = 4'ha,
    CondLt = 4'hb,
    CondGt = 4'hc,
    CondLe = 4'hd,
    CondAl = 4'he,
    CondNv = 4'hf
  } condT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    aluOpT       aluOp;
    condT        cond;
    logic        setFlags;
    logic        writesReg;  // Low for TST, TEQ, CMP, CMN
    logic        isRtype;    // Rm shifted by immediate
    logic        isRSRtype;  // Rm shifted by Rs
    shiftOpT     shiftOp;
    logic [4:0]  shiftImm;   // Instr[11:7]
  } execCtrlT;

  localparam flagsT flagsResetC = '0;

endpackage
